// File: Bender.yml
package:
  name: note_finder

sources:
  - files:
      - source/NoteFinderPkg.sv
      - source/BinLoader.sv
      - source/PeakScanner.sv
      - source/SlotMerger.sv
      - source/NoteReadPort.sv
      - source/NoteFinderTop.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/NoteFinderTb.sv

// File: build.f
+incdir+testbench
source/NoteFinderPkg.sv
source/BinLoader.sv
source/PeakScanner.sv
source/SlotMerger.sv
source/NoteReadPort.sv
source/NoteFinderTop.sv
testbench/NoteFinderTb.sv

// File: source/BinLoader.sv
`timescale 1ns/1ps

module BinLoader
    import NoteFinderPkg::*;
#(
    parameter int NumOctaves = 5
)
(
    input  logic          clk,
    input  logic          rst,
    input  axiLiteReq_t   axiReq,
    output axiLiteWrRsp_t writeRsp,
    input  logic          busy,       // Scanner running, no writes accepted
    output binVal_t [NumOctaves*BinsPerOctave-1:0] binFrame,
    output binVal_t       threshold,  // Minimum peak height, exclusive
    output logic          frameStart  // Pulses on the cycle a start write transfers
);

    localparam int FrameBins = NumOctaves * BinsPerOctave;
    localparam int BinIdxW   = $clog2(FrameBins);

    logic                  accept;     // AW and W ready together for one cycle
    logic                  bValid;
    axiAddr_t              binOffset;  // Byte offset from the bin window base
    logic [AddrWidth-3:0]  wordOffset;
    logic [BinIdxW-1:0]    binIdx;
    logic                  isBin;
    logic                  isThreshold;
    logic                  isStart;

    // Merge the low bytes of a write into a 16 bit register under the byte strobes
    function automatic binVal_t applyStrobe(binVal_t oldVal, axiData_t data,
                                            logic [DataWidth/8-1:0] strb);
        binVal_t result;
        result = oldVal;
        for (int b = 0; b < BinWidth/8; b++)
        begin
            if (strb[b])
            begin
                result[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return result;
    endfunction

    always_comb
    begin
        binOffset   = axiReq.wr.awaddr - BinBase;
        wordOffset  = binOffset[AddrWidth-1:2]; // Byte lanes of the address are ignored
        binIdx      = BinIdxW'(wordOffset);
        // Bins past the frame end are dropped but still answered
        isBin       = (axiReq.wr.awaddr < ThresholdAddr) && (32'(wordOffset) < FrameBins);
        isThreshold = axiReq.wr.awaddr[AddrWidth-1:2] == ThresholdAddr[AddrWidth-1:2];
        isStart     = axiReq.wr.awaddr[AddrWidth-1:2] == StartAddr[AddrWidth-1:2];
    end

    assign frameStart = accept && isStart && !busy;

    assign writeRsp = '{
        awready: accept,
        wready:  accept,
        bvalid:  bValid,
        bresp:   RespOkay // Every write completes OKAY, mapped or not
    };

    // Handshake control
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            accept <= 1'b0;
            bValid <= 1'b0;
        end
        else
        begin
            // Both channels must be offered, nothing may be outstanding and the scan idle
            accept <= axiReq.wr.awvalid && axiReq.wr.wvalid && !accept && !bValid && !busy;
            if (accept)
            begin
                bValid <= 1'b1;
            end
            else if (axiReq.wr.bready)
            begin
                bValid <= 1'b0; // Response taken
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            threshold <= '0;
        end
        else if (accept && isThreshold)
        begin
            threshold <= applyStrobe(threshold, axiReq.wr.wdata, axiReq.wr.wstrb);
        end
    end

    // Frame storage
    always_ff @(posedge clk)
    begin
        if (accept && isBin)
        begin
            binFrame[binIdx] <= applyStrobe(binFrame[binIdx], axiReq.wr.wdata, axiReq.wr.wstrb);
        end
    end

endmodule

// File: source/NoteFinderPkg.sv
package NoteFinderPkg;

    localparam int BinWidth      = 16; // Bin magnitude, amplitude and threshold width
    localparam int BinsPerOctave = 24;
    localparam int SlotCount     = 12; // One slot per semitone, two bins each
    localparam int PosFracBits   = 11; // Position is 5.11 fixed point within an octave
    localparam int PosWidth      = 16;
    localparam int CountWidth    = 8;  // Published frame counter
    localparam int AddrWidth     = 12;
    localparam int DataWidth     = 32;

    typedef logic [BinWidth-1:0]  binVal_t;
    typedef logic [PosWidth-1:0]  notePos_t;
    typedef logic [3:0]           slotIdx_t;
    typedef logic [AddrWidth-1:0] axiAddr_t;
    typedef logic [DataWidth-1:0] axiData_t;

    // Candidate handed from the scanner to the merger, one per scan step
    typedef struct packed {
        logic     hasPeak;
        slotIdx_t slot;
        notePos_t position;
        binVal_t  amplitude;
        logic     lastStep; // Set on the final step of a frame
    } peakCand_t;

    typedef struct packed {
        logic     valid;
        notePos_t position;
        binVal_t  amplitude;
    } note_t;

    typedef struct packed {
        logic     awvalid;
        axiAddr_t awaddr;
        logic     wvalid;
        axiData_t wdata;
        logic [DataWidth/8-1:0] wstrb;
        logic     bready;
    } axiLiteWrReq_t;

    typedef struct packed {
        logic     arvalid;
        axiAddr_t araddr;
        logic     rready;
    } axiLiteRdReq_t;

    typedef struct packed {
        axiLiteWrReq_t wr;
        axiLiteRdReq_t rd;
    } axiLiteReq_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
    } axiLiteWrRsp_t;

    typedef struct packed {
        logic       arready;
        logic       rvalid;
        logic [1:0] rresp;
        axiData_t   rdata;
    } axiLiteRdRsp_t;

    typedef struct packed {
        axiLiteWrRsp_t wr;
        axiLiteRdRsp_t rd;
    } axiLiteRsp_t;

    // Write side map
    localparam axiAddr_t BinBase       = 12'h000; // Bin k at byte 4k
    localparam axiAddr_t ThresholdAddr = 12'h200;
    localparam axiAddr_t StartAddr     = 12'h204;
    // Read side map
    localparam axiAddr_t NoteBase      = 12'h000; // Slot s at byte 4s
    localparam axiAddr_t StatusAddr    = 12'h040;

    localparam logic [1:0] RespOkay = 2'b00;

endpackage

// File: source/NoteFinderTop.sv
`timescale 1ns/1ps

module NoteFinderTop
    import NoteFinderPkg::*;
#(
    parameter int NumOctaves = 5 // Frame length is NumOctaves times BinsPerOctave bins
)
(
    input  logic        clk,
    input  logic        rst,
    input  axiLiteReq_t axiReq,
    output axiLiteRsp_t axiRsp,
    output logic        finished // One-cycle pulse when a frame is published
);

    binVal_t [NumOctaves*BinsPerOctave-1:0] binFrame; // Whole frame, flat
    binVal_t                   threshold;
    logic                      frameStart;
    logic                      busy;         // Scan in progress, stalls the write side
    logic                      clearSlots;
    peakCand_t                 cand;
    note_t [SlotCount-1:0]     notes;        // Published slots
    logic [CountWidth-1:0]     frameCount;

    // Write slave owns the frame storage and the start command
    BinLoader #(
        .NumOctaves(NumOctaves)
    ) binLoader_i (
        .clk       (clk),
        .rst       (rst),
        .axiReq    (axiReq),
        .writeRsp  (axiRsp.wr),
        .busy      (busy),
        .binFrame  (binFrame),
        .threshold (threshold),
        .frameStart(frameStart)
    );

    PeakScanner #(
        .NumOctaves(NumOctaves)
    ) peakScanner_i (
        .clk       (clk),
        .rst       (rst),
        .binFrame  (binFrame),
        .threshold (threshold),
        .frameStart(frameStart),
        .busy      (busy),
        .clearSlots(clearSlots),
        .cand      (cand)
    );

    SlotMerger slotMerger_i (
        .clk       (clk),
        .rst       (rst),
        .clearSlots(clearSlots),
        .cand      (cand),
        .notes     (notes),
        .frameDone (finished),
        .frameCount(frameCount)
    );

    // Read slave returns published notes and status
    NoteReadPort noteReadPort_i (
        .clk       (clk),
        .rst       (rst),
        .axiReq    (axiReq),
        .readRsp   (axiRsp.rd),
        .notes     (notes),
        .busy      (busy),
        .frameCount(frameCount)
    );

endmodule

// File: source/NoteReadPort.sv
`timescale 1ns/1ps

module NoteReadPort
    import NoteFinderPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  axiLiteReq_t           axiReq,
    output axiLiteRdRsp_t         readRsp,
    input  note_t [SlotCount-1:0] notes,
    input  logic                  busy,
    input  logic [CountWidth-1:0] frameCount
);

    logic                 rValid;
    axiData_t             rData;      // Held until the master takes it
    axiData_t             readWord;   // Decoded word for the current AR address
    axiAddr_t             noteOffset;
    logic [AddrWidth-3:0] noteWord;
    slotIdx_t             noteIdx;
    logic [SlotCount-1:0] validMask;

    always_comb
    begin
        for (int i = 0; i < SlotCount; i++)
        begin
            validMask[i] = notes[i].valid;
        end

        noteOffset = axiReq.rd.araddr - NoteBase;
        noteWord   = noteOffset[AddrWidth-1:2];
        noteIdx    = slotIdx_t'(noteWord);

        readWord = '0; // Unmapped addresses and empty slots read as zero
        if (axiReq.rd.araddr[AddrWidth-1:2] == StatusAddr[AddrWidth-1:2])
        begin
            // Count on top, busy in bit 16, valid mask at the bottom
            readWord = {frameCount, 7'b0, busy, 4'b0, validMask};
        end
        else if (32'(noteWord) < SlotCount)
        begin
            if (notes[noteIdx].valid)
            begin
                readWord = {notes[noteIdx].position, notes[noteIdx].amplitude};
            end
        end
    end

    // Address accepted whenever the data slot is free
    assign readRsp = '{
        arready: !rValid,
        rvalid:  rValid,
        rresp:   RespOkay,
        rdata:   rData
    };

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rValid <= 1'b0;
        end
        else if (axiReq.rd.arvalid && !rValid)
        begin
            rValid <= 1'b1; // Data shows up the cycle after the AR transfer
        end
        else if (axiReq.rd.rready)
        begin
            rValid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (axiReq.rd.arvalid && !rValid)
        begin
            rData <= readWord;
        end
    end

endmodule

// File: source/PeakScanner.sv
`timescale 1ns/1ps

module PeakScanner
    import NoteFinderPkg::*;
#(
    parameter int NumOctaves = 5
)
(
    input  logic      clk,
    input  logic      rst,
    input  binVal_t [NumOctaves*BinsPerOctave-1:0] binFrame,
    input  binVal_t   threshold,
    input  logic      frameStart,
    output logic      busy,       // Scan active or last candidate still in flight
    output logic      clearSlots, // frameStart delayed by one cycle
    output peakCand_t cand        // Registered, one step behind the counters
);

    localparam int FrameBins = NumOctaves * BinsPerOctave;
    localparam int OctW      = (NumOctaves > 1) ? $clog2(NumOctaves) : 1;
    localparam int IdxW      = $clog2(FrameBins + 1);

    logic            active;
    logic [OctW-1:0] octave;
    slotIdx_t        slot;     // Runs fastest
    logic            finalStep;
    logic [IdxW-1:0] leftIdx;  // Frame index of the left bin of the pair
    logic [IdxW-1:0] rightIdx;
    binVal_t         farLeft;
    binVal_t         leftBin;
    binVal_t         rightBin;
    binVal_t         farRight;
    logic            leftPeak;
    logic            rightPeak;
    peakCand_t       candNext;

    // Strict local maximum that also clears the threshold
    function automatic logic isPeak(binVal_t lower, binVal_t here, binVal_t upper, binVal_t thr);
        return (lower < here) && (here > upper) && (here > thr);
    endfunction

    always_comb
    begin
        leftIdx  = IdxW'(octave * BinsPerOctave + slot * 2);
        rightIdx = leftIdx + 1'b1;
        leftBin  = binFrame[leftIdx];
        rightBin = binFrame[rightIdx];
        // Neighbors beyond either end of the frame read as zero
        farLeft  = (leftIdx == '0) ? '0 : binFrame[leftIdx - 1'b1];
        farRight = (rightIdx == IdxW'(FrameBins - 1)) ? '0 : binFrame[rightIdx + 1'b1];

        leftPeak  = isPeak(farLeft, leftBin, rightBin, threshold);
        rightPeak = isPeak(leftBin, rightBin, farRight, threshold);

        finalStep = (octave == OctW'(NumOctaves - 1)) && (slot == slotIdx_t'(SlotCount - 1));

        candNext.hasPeak   = active && (leftPeak || rightPeak);
        candNext.slot      = slot;
        // Left bin wins when both bins of the pair peak
        candNext.position  = notePos_t'({slot, !leftPeak}) << PosFracBits; // Whole bin, no fraction
        candNext.amplitude = leftPeak ? leftBin : rightBin;
        candNext.lastStep  = active && finalStep;
    end

    // Stay busy until the last candidate has reached the merger
    assign busy = active || cand.lastStep;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            active     <= 1'b0;
            octave     <= '0;
            slot       <= '0;
            clearSlots <= 1'b0;
            cand       <= '0;
        end
        else
        begin
            clearSlots <= frameStart;
            cand       <= candNext;
            if (frameStart)
            begin
                active <= 1'b1; // Counters already sit at zero between frames
                octave <= '0;
                slot   <= '0;
            end
            else if (active)
            begin
                if (finalStep)
                begin
                    active <= 1'b0;
                    octave <= '0;
                    slot   <= '0;
                end
                else if (slot == slotIdx_t'(SlotCount - 1))
                begin
                    slot   <= '0;
                    octave <= octave + 1'b1; // Next octave
                end
                else
                begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

endmodule

// File: source/SlotMerger.sv
`timescale 1ns/1ps

module SlotMerger
    import NoteFinderPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clearSlots, // Empties the working set before a scan
    input  peakCand_t             cand,
    output note_t [SlotCount-1:0] notes,      // Snapshot of the last finished frame
    output logic                  frameDone,
    output logic [CountWidth-1:0] frameCount
);

    note_t [SlotCount-1:0] work;     // Peaks collected so far in this frame
    note_t [SlotCount-1:0] workNext;
    note_t                 cur;      // Working slot addressed by the candidate
    note_t                 merged;
    logic [BinWidth:0]     ampSum;   // One extra bit so the divisor never wraps
    logic [2*BinWidth:0]   weighted;
    logic [2*BinWidth:0]   quotient;

    always_comb
    begin
        cur = work[cand.slot];

        // Amplitude weighted average of the stored and the new position
        ampSum   = {1'b0, cur.amplitude} + {1'b0, cand.amplitude};
        weighted = cur.amplitude * cur.position + cand.amplitude * cand.position;
        quotient = weighted / ampSum; // Truncates toward zero

        if (cur.valid)
        begin
            merged.valid     = 1'b1;
            merged.position  = quotient[PosWidth-1:0];
            merged.amplitude = ampSum[BinWidth-1:0]; // Stored sum wraps at 16 bits
        end
        else
        begin
            merged.valid     = 1'b1; // First peak in this slot is taken as is
            merged.position  = cand.position;
            merged.amplitude = cand.amplitude;
        end

        workNext = work;
        if (cand.hasPeak)
        begin
            workNext[cand.slot] = merged;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            work       <= '0;
            notes      <= '0;
            frameDone  <= 1'b0;
            frameCount <= '0;
        end
        else
        begin
            frameDone <= cand.lastStep;
            if (clearSlots)
            begin
                work <= '0;
            end
            else
            begin
                work <= workNext;
            end
            // Publish including the final candidate, so notes and count change with frameDone
            if (cand.lastStep)
            begin
                notes      <= workNext;
                frameCount <= frameCount + 1'b1;
            end
        end
    end

endmodule

// File: testbench/NoteFinderTbTasks.svh
task automatic axiWrite(input axiAddr_t addr, input axiData_t data);
    @(posedge clk);
    axiReq.wr.awvalid <= 1'b1;
    axiReq.wr.awaddr  <= addr;
    axiReq.wr.wvalid  <= 1'b1;
    axiReq.wr.wdata   <= data;
    axiReq.wr.wstrb   <= '1;
    do @(negedge clk); while (!(axiRsp.wr.awready && axiRsp.wr.wready));
    lastWriteCycle = cycleCount; // Both channels transfer at the coming edge
    @(posedge clk);
    axiReq.wr.awvalid <= 1'b0;
    axiReq.wr.wvalid  <= 1'b0;
    do @(negedge clk); while (!axiRsp.wr.bvalid);
    expectEqual("write response", 32'(RespOkay), 32'(axiRsp.wr.bresp));
    @(posedge clk);
    axiReq.wr.bready <= 1'b1; // Response waits one cycle before it is taken
    @(posedge clk);
    axiReq.wr.bready <= 1'b0;
endtask

task automatic axiRead(input axiAddr_t addr, output axiData_t data);
    @(posedge clk);
    axiReq.rd.arvalid <= 1'b1;
    axiReq.rd.araddr  <= addr;
    do @(negedge clk); while (!axiRsp.rd.arready);
    @(posedge clk);
    axiReq.rd.arvalid <= 1'b0;
    do @(negedge clk); while (!axiRsp.rd.rvalid);
    @(posedge clk);
    axiReq.rd.rready <= 1'b1; // Data waits one cycle before it is taken
    @(negedge clk);
    data = axiRsp.rd.rdata;
    expectEqual("read response", 32'(RespOkay), 32'(axiRsp.rd.rresp));
    @(posedge clk);
    axiReq.rd.rready <= 1'b0;
endtask

// Strict local maximum above the threshold, zero outside the frame
function automatic logic peakAt(int idx);
    int lower;
    int upper;
    lower = (idx == 0) ? 0 : frameModel[idx - 1];
    upper = (idx == FrameBins - 1) ? 0 : frameModel[idx + 1];
    return (frameModel[idx] > lower) && (frameModel[idx] > upper) && (frameModel[idx] > thrModel);
endfunction

task automatic modelFrame();
    int     base;
    int     pick;
    longint amp;
    longint pos;
    longint sum;
    for (int s = 0; s < SlotCount; s++)
    begin
        expValid[s] = 1'b0;
        expPos[s]   = 0;
        expAmp[s]   = 0;
    end
    for (int oct = 0; oct < NumOctaves; oct++)
    begin
        for (int s = 0; s < SlotCount; s++)
        begin
            base = oct * BinsPerOctave + 2 * s;
            pick = peakAt(base) ? 0 : 1; // Left bin first
            if (peakAt(base) || peakAt(base + 1))
            begin
                amp = frameModel[base + pick];
                pos = (2 * s + pick) * (1 << PosFracBits); // Integer bin, zero fraction
                if (!expValid[s])
                begin
                    expValid[s] = 1'b1;
                    expPos[s]   = int'(pos);
                    expAmp[s]   = int'(amp);
                end
                else
                begin
                    sum       = expAmp[s] + amp;
                    expPos[s] = int'((expAmp[s] * longint'(expPos[s]) + amp * pos) / sum);
                    expAmp[s] = int'(sum % 65536);
                end
            end
        end
    end
endtask

task automatic clearFrame(input int thr);
    thrModel = thr;
    for (int i = 0; i < FrameBins; i++)
    begin
        frameModel[i] = 0;
    end
endtask

task automatic loadFrame();
    axiWrite(ThresholdAddr, 32'(thrModel));
    for (int i = 0; i < FrameBins; i++)
    begin
        axiWrite(BinBase + axiAddr_t'(4 * i), 32'(frameModel[i]));
    end
endtask

task automatic startFrame();
    axiWrite(StartAddr, 32'h1);
    startCycle = lastWriteCycle; // frameStart pulses in the transfer cycle
    framesRun++;
endtask

task automatic waitFrame(input string testName);
    axiData_t status;
    do
    begin
        axiRead(StatusAddr, status);
    end
    while (status[16]);
    expectEqual({testName, " finished count"}, framesRun, finishCount);
    expectEqual({testName, " finished delay"}, FinishDelay, lastFinishCycle - startCycle);
    expectEqual({testName, " frame count"}, framesRun % 256, status[31:24]);
endtask

task automatic checkFrame(input string testName);
    axiData_t             word;
    axiData_t             expected;
    logic [SlotCount-1:0] mask;
    modelFrame();
    mask = '0;
    for (int s = 0; s < SlotCount; s++)
    begin
        axiRead(NoteBase + axiAddr_t'(4 * s), word);
        expected = expValid[s] ? {16'(expPos[s]), 16'(expAmp[s])} : '0;
        expectEqual($sformatf("%s slot %0d", testName, s), expected, word);
        mask[s] = expValid[s];
    end
    axiRead(StatusAddr, word);
    expectEqual({testName, " valid mask"}, 32'(mask), 32'(word[11:0]));
    expectEqual({testName, " busy"}, 32'h0, 32'(word[16]));
endtask

task automatic runFrame(input string testName);
    startFrame();
    waitFrame(testName);
    checkFrame(testName);
endtask

task automatic testAfterReset();
    axiData_t status;
    repeat (10) @(posedge clk);
    axiRead(StatusAddr, status);
    expectEqual("reset status", 32'h0, status);
    expectEqual("reset finished", 0, finishCount);
    @(negedge clk);
    expectEqual("reset bvalid", 32'h0, 32'(axiRsp.wr.bvalid));
    expectEqual("reset rvalid", 32'h0, 32'(axiRsp.rd.rvalid));
endtask

task automatic testThresholdAndEdges();
    clearFrame(100);
    frameModel[0]  = 500; // Edge peak in slot 0, left neighbor outside the frame
    frameModel[30] = 300; // Octave 1, slot 3
    frameModel[50] = 100; // Equal to the threshold, must not show
    frameModel[77] = 80;
    loadFrame();
    runFrame("threshold");
    expectEqual("threshold mask literal", 32'h0000_0009,
                32'({expValid[3], expValid[2], expValid[1], expValid[0]}));
    expectEqual("threshold edge bin", 32'h0000_01f4, {16'(expPos[0]), 16'(expAmp[0])});
endtask

task automatic testLeftPreference();
    clearFrame(20);
    frameModel[10] = 400; // Left bin peaks, slot 5
    frameModel[11] = 200;
    frameModel[13] = 600; // Only the right bin peaks, slot 6
    loadFrame();
    runFrame("left preference");
    expectEqual("left preference left pos", 10 << PosFracBits, expPos[5]);
    expectEqual("left preference right pos", 13 << PosFracBits, expPos[6]);
endtask

task automatic testOctaveFolding();
    clearFrame(50);
    frameModel[8]   = 1000; // Slot 4 in octaves 0, 2 and 4
    frameModel[57]  = 500;
    frameModel[104] = 250;
    loadFrame();
    runFrame("folding");
    expectEqual("folding sum", 1750, expAmp[4]);
endtask

task automatic testFrameReplacement();
    clearFrame(100);
    frameModel[1]  = 300;
    frameModel[26] = 400;
    loadFrame();
    runFrame("replace first");
    clearFrame(100);
    frameModel[14] = 200; // Slots 0 and 1 must drop out
    frameModel[41] = 600;
    loadFrame();
    runFrame("replace second");
endtask

task automatic testBackPressure();
    clearFrame(100);
    frameModel[40] = 700; // Octave 1, slot 8
    loadFrame();
    startFrame();
    axiWrite(BinBase + axiAddr_t'(4 * 41), 32'd900); // Issued while the scan runs
    assert (lastWriteCycle >= startCycle + FinishDelay)
    else stopOnError("Bin write was accepted while the scanner was busy");
    waitFrame("backpressure");
    checkFrame("backpressure");
    frameModel[41] = 900; // The held write must now move the peak to bin 41
    runFrame("backpressure landed");
endtask

task automatic testRandomFrames(input int count);
    for (int f = 0; f < count; f++)
    begin
        clearFrame($urandom % 512);
        for (int i = 0; i < FrameBins; i++)
        begin
            frameModel[i] = $urandom % 2048; // Five merged peaks stay below 16 bits
        end
        loadFrame();
        runFrame($sformatf("random %0d", f));
    end
endtask

// File: testbench/NoteFinderTb.sv
`timescale 1ns/1ps

module NoteFinderTb
    import NoteFinderPkg::*;
();

    localparam int NumOctaves  = 5;
    localparam int FrameBins   = NumOctaves * BinsPerOctave;
    localparam int FinishDelay = NumOctaves * SlotCount + 2; // Start transfer to finished pulse
    // About 11 frames of 121 writes at 5 cycles plus reads and polls, padded to over 2x
    localparam int CycleLimit  = 20000;

    logic        clk;
    logic        rst;
    axiLiteReq_t axiReq;
    axiLiteRsp_t axiRsp;
    logic        finished;

    int cycleCount      = 0;
    int finishCount     = 0; // Finished pulses seen since reset
    int lastFinishCycle = 0;
    int startCycle      = 0; // Cycle in which the last start write transferred
    int lastWriteCycle  = 0;
    int framesRun       = 0;

    // Host side copy of the frame and the slots the model expects from it
    int   frameModel [FrameBins];
    int   thrModel;
    logic expValid [SlotCount];
    int   expPos [SlotCount];
    int   expAmp [SlotCount];

    NoteFinderTop #(
        .NumOctaves(NumOctaves)
    ) dut_i (
        .clk     (clk),
        .rst     (rst),
        .axiReq  (axiReq),
        .axiRsp  (axiRsp),
        .finished(finished)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic expectEqual(input string testName, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else stopOnError($sformatf("FAILED %s expected %h actual %h", testName, expected, actual));
    endtask

    `include "NoteFinderTbTasks.svh"

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit)
        begin
            stopOnError($sformatf("Timeout after %0d cycles, the DUT stopped answering", CycleLimit));
        end
    end

    // Counted mid-cycle where the DUT outputs have settled
    always @(negedge clk)
    begin
        if (finished)
        begin
            finishCount++;
            lastFinishCycle = cycleCount;
        end
    end

    // Slave responses are held until taken and never appear on their own
    assert property (@(posedge clk) disable iff (rst)
        axiRsp.wr.bvalid && !axiReq.wr.bready |=> axiRsp.wr.bvalid)
    else stopOnError("Write response withdrawn before bready");
    assert property (@(posedge clk) disable iff (rst)
        axiRsp.rd.rvalid && !axiReq.rd.rready |=>
        axiRsp.rd.rvalid && $stable(axiRsp.rd.rdata))
    else stopOnError("Read data withdrawn or changed before rready");
    assert property (@(posedge clk) disable iff (rst)
        $rose(axiRsp.wr.bvalid) |-> $past(axiRsp.wr.awready && axiReq.wr.awvalid))
    else stopOnError("Write response raised without an accepted write");
    assert property (@(posedge clk) disable iff (rst)
        $rose(axiRsp.rd.rvalid) |-> $past(axiRsp.rd.arready && axiReq.rd.arvalid))
    else stopOnError("Read data raised without an accepted read");
    assert property (@(posedge clk) disable iff (rst) finished |=> !finished)
    else stopOnError("Finished stayed high for more than one cycle");

    initial
    begin
        void'($urandom(37858));
        axiReq = '0;
        rst    = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        testAfterReset();
        testThresholdAndEdges();
        testLeftPreference();
        testOctaveFolding();
        testFrameReplacement();
        testBackPressure();
        testRandomFrames(4);

        $display("TEST PASS");
        $finish;
    end

endmodule
